// ==== common/mem_map_pkg.sv ====
package mem_map_pkg;

	// bus widths
	localparam int SDRAM_ADDR_W = 25;
	localparam int CPU_ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [SDRAM_ADDR_W-1:0] sdram_addr_t;
	typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
	typedef logic [DATA_W-1:0] mem_data_t;

	// SDRAM byte map
	//  00000-07fff main ram
	//  08000-08fff mos private ram (master)
	//  0a000-0bfff filing system ram (master)
	//  13000-17fff shadow ram (master)
	//  40000-7ffff sideways ram
	//  80000-dffff roms
	localparam logic [2:0] FS_RAM_PREFIX = 3'b101;

	// upper nibble of the rom areas
	localparam logic [3:0] MOS_ROM_NIBBLE = 4'h8;
	localparam logic [3:0] MODEL_B_ROM_NIBBLE = 4'h9;
	localparam logic [3:0] MASTER_ROM_NIBBLE = 4'ha;

endpackage

// ==== common/sys_ctrl_pkg.sv ====
package sys_ctrl_pkg;

	// positions in the osd status word
	localparam int STATUS_OSD_RESET = 0;
	localparam int STATUS_MODEL = 4;
	localparam int STATUS_ROMMAP = 5;
	localparam int STATUS_AUTOBOOT = 6;

	// download index codes
	localparam logic [7:0] IDX_ROM = 8'h00;
	localparam logic [7:0] IDX_CMOS = 8'hff;

	// sdram base of each download image
	localparam logic [24:0] ROM_LOAD_BASE = 25'h0080000;
	localparam logic [24:0] IMAGE_LOAD_BASE = 25'h0068000;

endpackage

// ==== mem/cpu_addr_map.sv ====
`timescale 1ns/1ps

module cpu_addr_map (
	input  mem_map_pkg::cpu_addr_t   mem_adr,
	input  logic [7:0]               mem_romsel,
	input  logic                     mem_acc_y,
	input  logic                     shadow_ram,
	input  logic                     shadow_vid,
	input  logic                     phi0,
	input  logic                     mem_we,
	input  logic                     model,
	input  logic                     rommap,
	output mem_map_pkg::sdram_addr_t cpu_sdram_addr,
	output logic                     cpu_we
);

	logic cpu_ram;
	logic mos_rom;
	logic sideways;
	logic mos_ram;
	logic filing_ram;
	logic sideways_ram;
	logic sideways_rom;
	logic [3:0] master_bank;

	// bbc address regions
	assign cpu_ram = ~mem_adr[15];
	assign mos_rom = (mem_adr[15:14] == 2'b11);
	assign sideways = (mem_adr[15:14] == 2'b10);
	assign mos_ram = sideways && (mem_adr[13:12] == 2'b00) && mem_romsel[7];
	assign filing_ram = (mem_adr[15:13] == 3'b110) && mem_acc_y;

	// banks 4 to 7 are sideways ram
	assign sideways_ram = sideways && (mem_romsel[3:2] == 2'b01);

	// master uses banks 0-3 and 8-f, model b picks high or low four
	always_comb begin
		if (model)
			sideways_rom = sideways && ((mem_romsel[3:2] == 2'b00) || mem_romsel[3]);
		else if (rommap)
			sideways_rom = sideways && (mem_romsel[3:2] == 2'b00);
		else
			sideways_rom = sideways && (mem_romsel[3:2] == 2'b11);
	end

	assign master_bank = mem_map_pkg::MASTER_ROM_NIBBLE + {2'b00, mem_romsel[3:2]};

	always_comb begin
		if (!phi0)
			// video fetch
			cpu_sdram_addr = {8'b0, shadow_vid, mem_adr};
		else if (cpu_ram || mos_ram)
			cpu_sdram_addr = {8'b0, shadow_ram, mem_adr};
		else if (filing_ram)
			cpu_sdram_addr = {9'b0, mem_map_pkg::FS_RAM_PREFIX, mem_adr[12:0]};
		else if (mos_rom)
			cpu_sdram_addr = {5'b0, mem_map_pkg::MOS_ROM_NIBBLE, 1'b0, model, mem_adr[13:0]};
		else if (sideways_rom && !model)
			cpu_sdram_addr = {5'b0, mem_map_pkg::MODEL_B_ROM_NIBBLE, mem_romsel[1:0],
				mem_adr[13:0]};
		else if (sideways_rom)
			cpu_sdram_addr = {5'b0, master_bank, mem_romsel[1:0], mem_adr[13:0]};
		else
			// sideways ram and unmapped banks
			cpu_sdram_addr = {6'b0, 1'b1, mem_romsel[3:0], mem_adr[13:0]};
	end

	assign cpu_we = mem_we && (cpu_ram || sideways_ram || mos_ram || filing_ram);

endmodule

// ==== mem/sdram_arbiter.sv ====
`timescale 1ns/1ps

module sdram_arbiter (
	input  logic                     clk_48m,
	input  logic                     reset,
	input  logic                     ioctl_download,
	input  mem_map_pkg::sdram_addr_t loader_addr,
	input  mem_map_pkg::mem_data_t   loader_data,
	input  logic                     loader_we,
	input  mem_map_pkg::sdram_addr_t cpu_sdram_addr,
	input  logic                     cpu_we,
	input  mem_map_pkg::mem_data_t   mem_do,
	output mem_map_pkg::sdram_addr_t sdram_adr,
	output logic                     sdram_we,
	output mem_map_pkg::mem_data_t   sdram_di
);

	// loader owns the port for the whole download
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			sdram_we <= 1'b0;
		end else if (ioctl_download) begin
			sdram_we <= loader_we;
		end else begin
			sdram_we <= cpu_we;
		end
	end

	always_ff @(posedge clk_48m) begin
		if (ioctl_download) begin
			sdram_adr <= loader_addr;
			sdram_di <= loader_data;
		end else begin
			sdram_adr <= cpu_sdram_addr;
			sdram_di <= mem_do;
		end
	end

endmodule

// ==== loader/rom_loader.sv ====
`timescale 1ns/1ps

module rom_loader (
	input  logic                     clk_48m,
	input  logic                     reset,
	input  logic                     mem_sync,
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  mem_map_pkg::sdram_addr_t ioctl_addr,
	input  mem_map_pkg::mem_data_t   ioctl_data,
	input  logic [7:0]               ioctl_index,
	output mem_map_pkg::sdram_addr_t loader_addr,
	output mem_map_pkg::mem_data_t   loader_data,
	output logic                     loader_we
);

	logic pending;
	logic take_wr;

	// cmos image goes elsewhere
	assign take_wr = ioctl_wr && ioctl_download && (ioctl_index != sys_ctrl_pkg::IDX_CMOS);

	// a new write wins over the slot clear
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			pending <= 1'b0;
			loader_we <= 1'b0;
		end else begin
			if (mem_sync) begin
				pending <= 1'b0;
				loader_we <= pending;
			end
			if (take_wr)
				pending <= 1'b1;
		end
	end

	always_ff @(posedge clk_48m) begin
		if (mem_sync && pending) begin
			if (ioctl_index == sys_ctrl_pkg::IDX_ROM)
				loader_addr <= ioctl_addr + sys_ctrl_pkg::ROM_LOAD_BASE;
			else
				loader_addr <= ioctl_addr + sys_ctrl_pkg::IMAGE_LOAD_BASE;
			loader_data <= ioctl_data;
		end
	end

endmodule

// ==== verilog/reset_ctrl.sv ====
`timescale 1ns/1ps

module reset_ctrl #(
	parameter int REMAP_CYCLES = 4095,
	parameter int AUTOBOOT_CYCLES = 32000000
) (
	input  logic clk_48m,
	input  logic reset,
	input  logic mem_sync,
	input  logic sdram_ready,
	input  logic osd_reset,
	input  logic core_button,
	input  logic ioctl_download,
	input  logic model,
	input  logic rommap,
	input  logic autoboot,
	output logic core_reset,
	output logic autoboot_shift
);

	localparam int REMAP_W = $clog2(REMAP_CYCLES + 1);
	localparam int AUTOBOOT_W = $clog2(AUTOBOOT_CYCLES + 1);
	localparam logic [REMAP_W-1:0] REMAP_LOAD = REMAP_CYCLES[REMAP_W-1:0];
	localparam logic [AUTOBOOT_W-1:0] AUTOBOOT_LOAD = AUTOBOOT_CYCLES[AUTOBOOT_W-1:0];

	logic last_model;
	logic last_rommap;
	logic [REMAP_W-1:0] remap_cnt;
	logic [AUTOBOOT_W-1:0] autoboot_cnt;
	logic reset_request;

	// hold the machine in reset a while after a model or mapping change
	always_ff @(posedge clk_48m) begin
		last_model <= model;
		last_rommap <= rommap;
		if (reset)
			remap_cnt <= '0;
		else if (last_model != model || last_rommap != rommap)
			remap_cnt <= REMAP_LOAD;
		else if (remap_cnt != 0)
			remap_cnt <= remap_cnt - 1'b1;
	end

	assign reset_request = reset || !sdram_ready || osd_reset || core_button ||
		ioctl_download || (remap_cnt != 0);

	// only change on a memory slot boundary
	always_ff @(posedge clk_48m) begin
		if (reset)
			core_reset <= 1'b1;
		else if (mem_sync)
			core_reset <= reset_request;
	end

	// shift key held for a while after reset
	always_ff @(posedge clk_48m) begin
		if (reset)
			autoboot_cnt <= '0;
		else if (core_reset)
			autoboot_cnt <= AUTOBOOT_LOAD;
		else if (autoboot_cnt != 0)
			autoboot_cnt <= autoboot_cnt - 1'b1;
	end

	assign autoboot_shift = autoboot && (autoboot_cnt != 0);

endmodule

// ==== verilog/bbc_mem_top.sv ====
`timescale 1ns/1ps

module bbc_mem_top #(
	parameter int REMAP_CYCLES = 4095,
	parameter int AUTOBOOT_CYCLES = 32000000
) (
	input  logic                     clk_48m,
	input  logic                     reset,
	input  logic                     sdram_ready,
	input  logic                     core_button,
	input  logic [7:0]               status,
	input  mem_map_pkg::cpu_addr_t   mem_adr,
	input  logic [7:0]               mem_romsel,
	input  logic                     mem_acc_y,
	input  logic                     shadow_ram,
	input  logic                     shadow_vid,
	input  logic                     phi0,
	input  logic                     mem_we,
	input  mem_map_pkg::mem_data_t   mem_do,
	input  logic                     mem_sync,
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  mem_map_pkg::sdram_addr_t ioctl_addr,
	input  mem_map_pkg::mem_data_t   ioctl_data,
	input  logic [7:0]               ioctl_index,
	output mem_map_pkg::sdram_addr_t sdram_adr,
	output logic                     sdram_we,
	output mem_map_pkg::mem_data_t   sdram_di,
	output logic                     core_reset,
	output logic                     autoboot_shift,
	output logic                     led
);

	logic model;
	logic rommap;
	logic autoboot;
	logic osd_reset;
	mem_map_pkg::sdram_addr_t cpu_sdram_addr;
	logic cpu_we;
	mem_map_pkg::sdram_addr_t loader_addr;
	mem_map_pkg::mem_data_t loader_data;
	logic loader_we;

	// osd menu options
	assign model = status[sys_ctrl_pkg::STATUS_MODEL];
	assign rommap = status[sys_ctrl_pkg::STATUS_ROMMAP];
	assign autoboot = status[sys_ctrl_pkg::STATUS_AUTOBOOT];
	assign osd_reset = status[sys_ctrl_pkg::STATUS_OSD_RESET];

	// led is lit while idle
	assign led = ~ioctl_download;

	cpu_addr_map u_cpu_addr_map (
		.mem_adr        (mem_adr),
		.mem_romsel     (mem_romsel),
		.mem_acc_y      (mem_acc_y),
		.shadow_ram     (shadow_ram),
		.shadow_vid     (shadow_vid),
		.phi0           (phi0),
		.mem_we         (mem_we),
		.model          (model),
		.rommap         (rommap),
		.cpu_sdram_addr (cpu_sdram_addr),
		.cpu_we         (cpu_we)
	);

	rom_loader u_rom_loader (
		.clk_48m        (clk_48m),
		.reset          (reset),
		.mem_sync       (mem_sync),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ioctl_index    (ioctl_index),
		.loader_addr    (loader_addr),
		.loader_data    (loader_data),
		.loader_we      (loader_we)
	);

	sdram_arbiter u_sdram_arbiter (
		.clk_48m        (clk_48m),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.loader_addr    (loader_addr),
		.loader_data    (loader_data),
		.loader_we      (loader_we),
		.cpu_sdram_addr (cpu_sdram_addr),
		.cpu_we         (cpu_we),
		.mem_do         (mem_do),
		.sdram_adr      (sdram_adr),
		.sdram_we       (sdram_we),
		.sdram_di       (sdram_di)
	);

	reset_ctrl #(
		.REMAP_CYCLES    (REMAP_CYCLES),
		.AUTOBOOT_CYCLES (AUTOBOOT_CYCLES)
	) u_reset_ctrl (
		.clk_48m        (clk_48m),
		.reset          (reset),
		.mem_sync       (mem_sync),
		.sdram_ready    (sdram_ready),
		.osd_reset      (osd_reset),
		.core_button    (core_button),
		.ioctl_download (ioctl_download),
		.model          (model),
		.rommap         (rommap),
		.autoboot       (autoboot),
		.core_reset     (core_reset),
		.autoboot_shift (autoboot_shift)
	);

endmodule

// ==== tb/bbc_mem_checker.sv ====
`timescale 1ns/1ps

module bbc_mem_checker (
	input mem_map_pkg::sdram_addr_t sdram_adr,
	input logic                     sdram_we,
	input mem_map_pkg::mem_data_t   sdram_di
);

	int mismatch_count = 0;
	int fail_count = 0;

	// reference map
	// fl is {we, phi0, shadow_vid, shadow_ram, acc_y}
	function automatic logic [24:0] map_address(input logic [15:0] a, input logic [7:0] rs,
		input logic [4:0] fl, input logic model, input logic rommap);
		logic sw;
		logic swrom;
		sw = (a[15:14] == 2'b10);
		case ({model, rommap})
			2'b00: swrom = sw && (rs[3:2] == 2'b11);
			2'b01: swrom = sw && (rs[3:2] == 2'b00);
			default: swrom = sw && (rs[3] || rs[2] == 1'b0);
		endcase
		if (!fl[3])
			return {8'h00, fl[2], a};
		if (!a[15] || (sw && a[13:12] == 2'b00 && rs[7]))
			return {8'h00, fl[1], a};
		if (a[15:13] == 3'b110 && fl[0])
			return 25'h0a000 + {12'b0, a[12:0]};
		if (a[15:14] == 2'b11)
			return 25'h80000 + {10'b0, model, a[13:0]};
		if (swrom && !model)
			return 25'h90000 + {9'b0, rs[1:0], a[13:0]};
		if (swrom)
			return 25'ha0000 + {7'b0, rs[3:2], 16'h0} + {9'b0, rs[1:0], a[13:0]};
		return 25'h40000 + {7'b0, rs[3:0], a[13:0]};
	endfunction

	function automatic logic write_permitted(input logic [15:0] a, input logic [7:0] rs,
		input logic [4:0] fl);
		logic sw;
		sw = (a[15:14] == 2'b10);
		return fl[4] && (!a[15] || (sw && rs[3:2] == 2'b01) ||
			(sw && a[13:12] == 2'b00 && rs[7]) || (a[15:13] == 3'b110 && fl[0]));
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic verify_bus(input logic [24:0] exp_adr, input logic exp_we,
		input logic [7:0] exp_di);
		check_value("sdram_adr", sdram_adr, exp_adr);
		check_value("sdram_we", sdram_we, exp_we);
		// data only matters on a write
		if (exp_we)
			check_value("sdram_di", sdram_di, exp_di);
	endtask

	task automatic report_error(input string what);
		$display("error: %s", what);
		fail_count++;
	endtask

endmodule

// ==== tb/bbc_mem_asserts.sv ====
`timescale 1ns/1ps

module bbc_mem_asserts (
	input logic clk_48m,
	input logic reset,
	input logic mem_sync,
	input logic ioctl_download,
	input logic cpu_we,
	input logic sdram_we,
	input logic core_reset,
	input logic led
);

	int assert_fail_count = 0;

	// outside a download only a cpu write may reach the sdram
	a_we_source: assert property (@(posedge clk_48m) disable iff (reset)
		sdram_we && !ioctl_download && !$past(ioctl_download) |-> $past(cpu_we))
		else begin
			$error("sdram_we high without a cpu write request");
			assert_fail_count++;
		end

	// core reset moves on memory slot boundaries
	a_reset_slot: assert property (@(posedge clk_48m) disable iff (reset)
		(core_reset != $past(core_reset)) && !$past(reset) |-> $past(mem_sync))
		else begin
			$error("core_reset changed outside a mem_sync clock");
			assert_fail_count++;
		end

	a_led: assert property (@(posedge clk_48m) led == !ioctl_download)
		else begin
			$error("led does not follow the download state");
			assert_fail_count++;
		end

endmodule

bind bbc_mem_top bbc_mem_asserts u_asserts (
	.clk_48m        (clk_48m),
	.reset          (reset),
	.mem_sync       (mem_sync),
	.ioctl_download (ioctl_download),
	.cpu_we         (cpu_we),
	.sdram_we       (sdram_we),
	.core_reset     (core_reset),
	.led            (led)
);

// ==== tb/tb_bbc_mem.sv ====
`timescale 1ns/1ps

module tb_bbc_mem;

	localparam int REMAP_CYCLES = 20;
	localparam int AUTOBOOT_CYCLES = 50;
	localparam int N_RANDOM = 10;
	localparam logic [1:0] PH_CPU = 2'd0;
	localparam logic [1:0] PH_LOAD = 2'd1;
	localparam logic [1:0] PH_CTRL = 2'd2;

	// flags are {we, phi0, shadow_vid, shadow_ram, acc_y}
	// sel is romsel for cpu rows, ioctl_index for load rows, reset source for ctrl rows
	// ctrl rows use flags[0] as autoboot and exp_we as the expected autoboot_shift
	typedef struct packed {
		logic [1:0]  phase;
		logic [24:0] addr;
		logic [7:0]  sel;
		logic [4:0]  flags;
		logic        model;
		logic        rommap;
		logic [7:0]  data;
		logic [24:0] exp_addr;
		logic        exp_we;
	} row_t;

	row_t rows[0:31];
	int n_rows = 0;
	logic clk_48m = 1'b0;
	logic [1:0] sync_cnt;
	logic reset;
	logic sdram_ready;
	logic core_button;
	logic [7:0] status;
	mem_map_pkg::cpu_addr_t mem_adr;
	logic [7:0] mem_romsel;
	logic mem_acc_y;
	logic shadow_ram;
	logic shadow_vid;
	logic phi0;
	logic mem_we;
	mem_map_pkg::mem_data_t mem_do;
	logic mem_sync;
	logic ioctl_download;
	logic ioctl_wr;
	mem_map_pkg::sdram_addr_t ioctl_addr;
	mem_map_pkg::mem_data_t ioctl_data;
	logic [7:0] ioctl_index;
	mem_map_pkg::sdram_addr_t sdram_adr;
	logic sdram_we;
	mem_map_pkg::mem_data_t sdram_di;
	logic core_reset;
	logic autoboot_shift;
	logic led;

	bbc_mem_top #(
		.REMAP_CYCLES    (REMAP_CYCLES),
		.AUTOBOOT_CYCLES (AUTOBOOT_CYCLES)
	) u_dut (.*);

	bbc_mem_checker u_checker (
		.sdram_adr (sdram_adr),
		.sdram_we  (sdram_we),
		.sdram_di  (sdram_di)
	);

	always #5 clk_48m = ~clk_48m;

	// one memory slot every four clocks
	always @(posedge clk_48m) begin
		#1;
		sync_cnt = sync_cnt + 1'b1;
		mem_sync = (sync_cnt == 2'd0);
	end

	task automatic add_row(input logic [1:0] phase, input logic [24:0] addr,
		input logic [7:0] sel, input logic [4:0] flags, input logic model,
		input logic rommap, input logic [7:0] data, input logic [24:0] exp_addr,
		input logic exp_we);
		rows[n_rows] = {phase, addr, sel, flags, model, rommap, data, exp_addr, exp_we};
		n_rows++;
	endtask

	task automatic finish_run;
		$display("mismatches %0d, other errors %0d, assertion failures %0d",
			u_checker.mismatch_count, u_checker.fail_count,
			u_dut.u_asserts.assert_fail_count);
		if (u_checker.mismatch_count == 0 && u_checker.fail_count == 0 &&
			u_dut.u_asserts.assert_fail_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	function automatic logic watched(input int code);
		case (code)
			0: return core_reset;
			1: return sdram_we;
			default: return autoboot_shift;
		endcase
	endfunction

	task automatic wait_level(input int code, input logic want, input int limit,
		input string what, output int n);
		n = 0;
		while (watched(code) !== want && n < limit) begin
			@(posedge clk_48m);
			#1;
			n++;
		end
		if (watched(code) !== want)
			u_checker.report_error({"timeout waiting for ", what});
	endtask

	task automatic cpu_access(input row_t r);
		status[sys_ctrl_pkg::STATUS_MODEL] = r.model;
		status[sys_ctrl_pkg::STATUS_ROMMAP] = r.rommap;
		mem_adr = r.addr[15:0];
		mem_romsel = r.sel;
		{mem_we, phi0, shadow_vid, shadow_ram, mem_acc_y} = r.flags;
		mem_do = r.data;
		@(posedge clk_48m);
		#1;
		u_checker.verify_bus(r.exp_addr, r.exp_we, r.data);
		mem_we = 1'b0;
	endtask

	task automatic rom_download(input row_t r);
		int n;
		logic seen;
		ioctl_download = 1'b1;
		ioctl_addr = r.addr;
		ioctl_index = r.sel;
		ioctl_data = r.data;
		ioctl_wr = 1'b1;
		@(posedge clk_48m);
		#1;
		ioctl_wr = 1'b0;
		seen = 1'b0;
		// write shows up one slot after it is taken
		for (n = 0; n < 16 && !seen; n++) begin
			@(posedge clk_48m);
			#1;
			seen = sdram_we;
		end
		u_checker.check_value("sdram_we", seen, r.exp_we);
		if (seen)
			u_checker.verify_bus(r.exp_addr, 1'b1, r.data);
		wait_level(1, 1'b0, 8, "sdram_we to drop after a download write", n);
		ioctl_download = 1'b0;
	endtask

	task automatic reset_source(input row_t r);
		int n;
		int held;
		wait_level(0, 1'b0, 64, "core_reset to drop before a reset source", n);
		status[sys_ctrl_pkg::STATUS_AUTOBOOT] = r.flags[0];
		case (r.sel)
			8'd0: core_button = 1'b1;
			8'd1: status[sys_ctrl_pkg::STATUS_OSD_RESET] = 1'b1;
			8'd2: sdram_ready = 1'b0;
			default: status[sys_ctrl_pkg::STATUS_MODEL] = ~status[sys_ctrl_pkg::STATUS_MODEL];
		endcase
		// a model change needs one clock to load the remap counter
		wait_level(0, 1'b1, (r.sel == 8'd3) ? 5 : 4, "core_reset to rise on a reset source",
			n);
		core_button = 1'b0;
		status[sys_ctrl_pkg::STATUS_OSD_RESET] = 1'b0;
		sdram_ready = 1'b1;
		wait_level(0, 1'b0, 64, "core_reset to drop after a reset source", held);
		if (r.sel == 8'd3 && held < REMAP_CYCLES)
			u_checker.report_error("core_reset too short after a model change");
		u_checker.check_value("autoboot_shift", autoboot_shift, r.exp_we);
		if (r.exp_we) begin
			wait_level(2, 1'b0, AUTOBOOT_CYCLES + 1, "autoboot_shift to drop", held);
			if (held < AUTOBOOT_CYCLES)
				u_checker.report_error("autoboot_shift dropped too early");
		end
	endtask

	initial begin
		int i;
		int n;
		logic [15:0] a;
		logic [7:0] rs;
		logic [4:0] fl;
		logic md;
		logic rm;
		logic [7:0] d;
		void'($urandom(33));
		reset = 1'b1;
		sdram_ready = 1'b1;
		core_button = 1'b0;
		status = 8'h00;
		mem_adr = '0;
		mem_romsel = 8'h00;
		mem_acc_y = 1'b0;
		shadow_ram = 1'b0;
		shadow_vid = 1'b0;
		phi0 = 1'b1;
		mem_we = 1'b0;
		mem_do = '0;
		mem_sync = 1'b0;
		sync_cnt = 2'd0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_data = '0;
		ioctl_index = 8'h00;

		// ram, shadow, video, mos ram, filing ram
		add_row(PH_CPU, 25'h01234, 8'h00, 5'b11000, 1'b0, 1'b0, 8'h5a, 25'h01234, 1'b1);
		add_row(PH_CPU, 25'h03000, 8'h00, 5'b11010, 1'b0, 1'b0, 8'h11, 25'h13000, 1'b1);
		add_row(PH_CPU, 25'h03000, 8'h00, 5'b00100, 1'b0, 1'b0, 8'h22, 25'h13000, 1'b0);
		add_row(PH_CPU, 25'h08100, 8'h80, 5'b11000, 1'b1, 1'b0, 8'h33, 25'h08100, 1'b1);
		add_row(PH_CPU, 25'h0c123, 8'h00, 5'b11001, 1'b1, 1'b0, 8'h44, 25'h0a123, 1'b1);
		// mos rom and sideways banks
		add_row(PH_CPU, 25'h0c123, 8'h00, 5'b11000, 1'b0, 1'b0, 8'h55, 25'h80123, 1'b0);
		add_row(PH_CPU, 25'h0fffc, 8'h00, 5'b01000, 1'b1, 1'b0, 8'h66, 25'h87ffc, 1'b0);
		add_row(PH_CPU, 25'h09000, 8'h0f, 5'b11000, 1'b0, 1'b0, 8'h77, 25'h9d000, 1'b0);
		add_row(PH_CPU, 25'h08000, 8'h02, 5'b11000, 1'b0, 1'b1, 8'h88, 25'h98000, 1'b0);
		add_row(PH_CPU, 25'h08000, 8'h02, 5'b11000, 1'b0, 1'b0, 8'h99, 25'h48000, 1'b0);
		add_row(PH_CPU, 25'h0a000, 8'h05, 5'b11000, 1'b0, 1'b0, 8'haa, 25'h56000, 1'b1);
		add_row(PH_CPU, 25'h0b000, 8'h0e, 5'b01000, 1'b1, 1'b0, 8'hbb, 25'hdb000, 1'b0);
		// rom, other image, cmos
		add_row(PH_LOAD, 25'h01234, 8'h00, 5'b00000, 1'b0, 1'b0, 8'ha5, 25'h81234, 1'b1);
		add_row(PH_LOAD, 25'h00010, 8'h03, 5'b00000, 1'b0, 1'b0, 8'h3c, 25'h68010, 1'b1);
		add_row(PH_LOAD, 25'h00005, 8'hff, 5'b00000, 1'b0, 1'b0, 8'h77, 25'h00000, 1'b0);
		// button, model change, sdram not ready, osd reset
		add_row(PH_CTRL, 25'h00000, 8'd0, 5'b00001, 1'b0, 1'b0, 8'h00, 25'h00000, 1'b1);
		add_row(PH_CTRL, 25'h00000, 8'd3, 5'b00000, 1'b0, 1'b0, 8'h00, 25'h00000, 1'b0);
		add_row(PH_CTRL, 25'h00000, 8'd2, 5'b00001, 1'b0, 1'b0, 8'h00, 25'h00000, 1'b1);
		add_row(PH_CTRL, 25'h00000, 8'd1, 5'b00000, 1'b0, 1'b0, 8'h00, 25'h00000, 1'b0);
		for (i = 0; i < N_RANDOM; i++) begin
			a = $urandom_range(0, 16'hffff);
			rs = $urandom_range(0, 8'hff);
			fl = $urandom_range(0, 5'h1f);
			md = $urandom_range(0, 1);
			rm = $urandom_range(0, 1);
			d = $urandom_range(0, 8'hff);
			add_row(PH_CPU, {9'b0, a}, rs, fl, md, rm, d,
				u_checker.map_address(a, rs, fl, md, rm),
				u_checker.write_permitted(a, rs, fl));
		end

		repeat (16) @(posedge clk_48m);
		#1;
		reset = 1'b0;
		wait_level(0, 1'b0, 64, "core_reset to drop after reset", n);
		for (i = 0; i < n_rows; i++) begin
			case (rows[i].phase)
				PH_CPU: cpu_access(rows[i]);
				PH_LOAD: rom_download(rows[i]);
				default: reset_source(rows[i]);
			endcase
		end
		finish_run();
	end

endmodule

// ==== verilog.f ====
common/mem_map_pkg.sv
common/sys_ctrl_pkg.sv
mem/cpu_addr_map.sv
mem/sdram_arbiter.sv
loader/rom_loader.sv
verilog/reset_ctrl.sv
verilog/bbc_mem_top.sv
tb/bbc_mem_checker.sv
tb/bbc_mem_asserts.sv
tb/tb_bbc_mem.sv
